/* logic/periph_pkg.sv */
package periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // all zero means read

  // address map seen by the host
  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t clint_span = 32'h0001_0000;
  localparam addr_t ram_base = 32'h8000_0000;

  // timer register offsets inside the clint window
  localparam addr_t msip_offset = 32'h0000_0000;
  localparam addr_t mtimecmp_offset = 32'h0000_4000;
  localparam addr_t mtime_offset = 32'h0000_BFF8;  // 64-bit, low word first

endpackage

/* logic/mem_bus_if.sv */
interface mem_bus_if import periph_pkg::*; ();

  // request side
  logic valid;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;

  // response side, one cycle after valid
  data_t rdata;
  logic ready;
  logic error;

  modport host (
    output valid, addr, wdata, wstrb,
    input rdata, ready, error
  );

  modport target (
    input valid, addr, wdata, wstrb,
    output rdata, ready, error
  );

  modport monitor (
    input rdata, ready, error
  );

endinterface

/* logic/bus_decoder.sv */
module bus_decoder import periph_pkg::*; #(
  parameter int ram_words = 64
) (
  input logic mem_valid,
  input addr_t mem_addr,
  input data_t mem_wdata,
  input strb_t mem_wstrb,
  mem_bus_if.host clint_bus,
  mem_bus_if.host ram_bus,
  output logic miss
);

  localparam addr_t ram_span = addr_t'(ram_words * ($bits(data_t) / 8));

  addr_t clint_offset;
  addr_t ram_offset;
  logic hit_clint;
  logic hit_ram;

  // unsigned subtract wraps addresses below the base out of range
  assign clint_offset = mem_addr - clint_base;
  assign ram_offset = mem_addr - ram_base;

  assign hit_clint = clint_offset < clint_span;
  assign hit_ram = ram_offset < ram_span;

  assign clint_bus.valid = mem_valid & hit_clint;
  assign clint_bus.addr = clint_offset;
  assign clint_bus.wdata = mem_wdata;
  assign clint_bus.wstrb = mem_wstrb;

  assign ram_bus.valid = mem_valid & hit_ram;
  assign ram_bus.addr = ram_offset;
  assign ram_bus.wdata = mem_wdata;
  assign ram_bus.wstrb = mem_wstrb;

  assign miss = mem_valid & ~hit_clint & ~hit_ram;  // answered by response_merge

endmodule

/* logic/clint.sv */
module clint import periph_pkg::*; #(
  parameter int clock_rate = 8
) (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus,
  output logic [63:0] mtime,
  output logic msip,
  output logic mtip
);

  localparam int half = clock_rate / 2;
  localparam int count_width = (half > 1) ? $clog2(half) : 1;
  localparam logic [count_width-1:0] count_last = count_width'(half - 1);

  logic [count_width-1:0] count;
  logic tick;
  logic [63:0] mtimecmp;

  logic sel_msip;
  logic sel_mtimecmp;
  logic sel_mtime;
  logic write;
  logic upper;
  data_t read_word;

  data_t rdata_q;
  logic ready_q;

  // msip is one word, the timer registers are two words each
  assign sel_msip = bus.addr[31:2] == msip_offset[31:2];
  assign sel_mtimecmp = bus.addr[31:3] == mtimecmp_offset[31:3];
  assign sel_mtime = bus.addr[31:3] == mtime_offset[31:3];
  assign write = |bus.wstrb;  // whole word on any lane
  assign upper = bus.addr[2];

  always_comb begin
    read_word = '0;
    if (sel_msip) begin
      read_word = {{($bits(data_t) - 1){1'b0}}, msip};
    end else if (sel_mtimecmp) begin
      read_word = upper ? mtimecmp[63:32] : mtimecmp[31:0];
    end else if (sel_mtime) begin
      read_word = upper ? mtime[63:32] : mtime[31:0];
    end
  end

  // every request in the window is answered, holes read as zero
  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    rdata_q <= (bus.valid && !write) ? read_word : '0;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      msip <= 1'b0;
    end else if (bus.valid && write && sel_msip) begin
      msip <= bus.wdata[0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtimecmp <= '0;
    end else if (bus.valid && write && sel_mtimecmp) begin
      if (upper) begin
        mtimecmp[63:32] <= bus.wdata;
      end else begin
        mtimecmp[31:0] <= bus.wdata;
      end
    end
  end

  // a host write wins over the tick in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
    end else if (bus.valid && write && sel_mtime) begin
      if (upper) begin
        mtime[63:32] <= bus.wdata;
      end else begin
        mtime[31:0] <= bus.wdata;
      end
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  // one tick every clock_rate/2 cycles
  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      tick <= 1'b0;
    end else if (count == count_last) begin
      count <= '0;
      tick <= 1'b1;
    end else begin
      count <= count + 1'b1;
      tick <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtip <= 1'b0;
    end else begin
      mtip <= mtime >= mtimecmp;  // lags the registers by one cycle
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;
  assign bus.error = 1'b0;

endmodule

/* logic/scratch_ram.sv */
module scratch_ram import periph_pkg::*; #(
  parameter int ram_words = 64
) (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus
);

  localparam int lane_bits = $clog2($bits(data_t) / 8);
  localparam int index_width = $clog2(ram_words);

  data_t mem [ram_words];
  logic [index_width-1:0] index;
  logic write;

  data_t rdata_q;
  logic ready_q;

  assign index = bus.addr[index_width+lane_bits-1:lane_bits];
  assign write = |bus.wstrb;

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bus.wstrb[b]) begin
          mem[index][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    rdata_q <= (bus.valid && !write) ? mem[index] : '0;  // writes return zero
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;
  assign bus.error = 1'b0;

endmodule

/* logic/response_merge.sv */
module response_merge import periph_pkg::*; (
  input logic clock,
  input logic reset,
  mem_bus_if.monitor clint_bus,
  mem_bus_if.monitor ram_bus,
  input logic miss,
  output data_t mem_rdata,
  output logic mem_ready,
  output logic mem_error
);

  logic miss_q;

  // unmapped request gets its error one cycle later, like a target
  always_ff @(posedge clock) begin
    if (!reset) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= miss;
    end
  end

  // at most one source answers per cycle
  always_comb begin
    if (clint_bus.ready) begin
      mem_rdata = clint_bus.rdata;
    end else if (ram_bus.ready) begin
      mem_rdata = ram_bus.rdata;
    end else begin
      mem_rdata = '0;  // error and idle
    end
  end

  assign mem_ready = clint_bus.ready | ram_bus.ready | miss_q;
  assign mem_error = miss_q | clint_bus.error | ram_bus.error;

endmodule

/* logic/periph_top.sv */
module periph_top import periph_pkg::*; #(
  parameter int clock_rate = 8,
  parameter int ram_words = 64
) (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input addr_t mem_addr,
  input data_t mem_wdata,
  input strb_t mem_wstrb,
  output data_t mem_rdata,
  output logic mem_ready,
  output logic mem_error,
  output logic [63:0] mtime,
  output logic msip,
  output logic mtip
);

  logic miss;

  mem_bus_if clint_bus ();
  mem_bus_if ram_bus ();

  bus_decoder #(
    .ram_words(ram_words)
  ) bus_decoder_inst (
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .clint_bus(clint_bus.host),
    .ram_bus(ram_bus.host),
    .miss(miss)
  );

  clint #(
    .clock_rate(clock_rate)
  ) clint_inst (
    .clock(clock),
    .reset(reset),
    .bus(clint_bus.target),
    .mtime(mtime),
    .msip(msip),
    .mtip(mtip)
  );

  scratch_ram #(
    .ram_words(ram_words)
  ) scratch_ram_inst (
    .clock(clock),
    .reset(reset),
    .bus(ram_bus.target)
  );

  response_merge response_merge_inst (
    .clock(clock),
    .reset(reset),
    .clint_bus(clint_bus.monitor),
    .ram_bus(ram_bus.monitor),
    .miss(miss),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .mem_error(mem_error)
  );

endmodule

/* tests/periph_checks.svh */
`ifndef periph_checks_svh
`define periph_checks_svh

task automatic check_data(data_t actual, data_t expected, string what);
  if (actual !== expected) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                        $time, what, actual, expected));
  end
endtask

task automatic check_flag(logic actual, logic expected, string what);
  if (actual !== expected) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                        $time, what, actual, expected));
  end
endtask

// inclusive range
task automatic check_time(logic [63:0] actual, logic [63:0] lo, logic [63:0] hi,
                          string what);
  if ($isunknown(actual) || actual < lo || actual > hi) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %0d outside %0d..%0d",
                        $time, what, actual, lo, hi));
  end
endtask

// one request, its response is owed on the next cycle
task automatic issue(addr_t addr, data_t data, strb_t strb);
  expect_t rsp;
  @(posedge clock);
  #1;
  mem_valid = 1'b1;
  mem_addr = addr;
  mem_wdata = data;
  mem_wstrb = strb;
  rsp.cycle = cycle;
  rsp.error = !in_ram(addr) && !in_clint(addr);
  rsp.ranged = 1'b0;
  rsp.data = (strb == '0) ? expected_read(addr) : '0;  // writes and misses read zero
  rsp.lo = '0;
  rsp.hi = '0;
  pending.push_back(rsp);
  update_model(addr, data, strb);
endtask

task automatic read_at(addr_t addr);
  issue(addr, $random(seed), '0);
endtask

// at most one tick per clock_rate/2 cycles since the write
task automatic read_mtime_low();
  expect_t rsp;
  issue(clint_base + mtime_offset, $random(seed), '0);
  rsp = pending.pop_back();
  rsp.ranged = 1'b1;
  rsp.lo = {32'd0, mtime_written};
  rsp.hi = rsp.lo + 64'((cycle - mtime_write_cycle) / (clock_rate / 2) + 1);
  pending.push_back(rsp);
endtask

task automatic idle_cycles(int count);
  repeat (count) begin
    @(posedge clock);
    #1;
    mem_valid = 1'b0;
    mem_wstrb = '0;
  end
endtask

`endif

/* tests/periph_tb.sv */
module periph_tb import periph_pkg::*; ();

  localparam int clock_rate = 8;
  localparam int ram_words = 64;
  localparam int period = 40;
  localparam int reset_cycles = 10;
  localparam int ram_pairs = 32;
  localparam int burst_len = 40;
  localparam int planned_requests = 4 * ram_words + 2 * ram_pairs + burst_len + 40;
  localparam int margin_cycles = 100;  // idle gaps and drain

  typedef struct packed {
    int unsigned cycle;
    logic error;
    logic ranged;
    data_t data;
    logic [63:0] lo;
    logic [63:0] hi;
  } expect_t;

  logic clock;
  logic reset;
  logic mem_valid;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_wstrb;
  data_t mem_rdata;
  logic mem_ready;
  logic mem_error;
  logic [63:0] mtime;
  logic msip;
  logic mtip;

  integer seed;
  int unsigned cycle;
  expect_t pending[$];  // oldest first

  data_t ram_model [ram_words];
  logic msip_model;
  logic [63:0] mtimecmp_model;
  data_t mtime_written;
  data_t mtime_high_written;
  int unsigned mtime_write_cycle;
  logic time_loaded;
  logic [63:0] prev_mtime;

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  function automatic logic in_ram(addr_t addr);
    return addr >= ram_base && addr < ram_base + addr_t'(ram_words * 4);
  endfunction

  function automatic logic in_clint(addr_t addr);
    return addr >= clint_base && addr < clint_base + clint_span;
  endfunction

  function automatic addr_t random_ram_addr();
    int idx;
    idx = int'($unsigned($random(seed)) % ram_words);
    return ram_base + addr_t'(idx * 4);
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t new_data, strb_t strb);
    data_t result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return result;
  endfunction

  // reference model of what a read returns
  function automatic data_t expected_read(addr_t addr);
    addr_t offset;
    offset = addr - clint_base;
    if (in_ram(addr)) return ram_model[(addr - ram_base) >> 2];
    if (!in_clint(addr)) return '0;
    if (offset == msip_offset) return {31'd0, msip_model};
    if (offset == mtimecmp_offset) return mtimecmp_model[31:0];
    if (offset == mtimecmp_offset + 4) return mtimecmp_model[63:32];
    if (offset == mtime_offset + 4) return mtime_high_written;  // no carry from small values
    return '0;
  endfunction

  task automatic update_model(addr_t addr, data_t data, strb_t strb);
    addr_t offset;
    offset = addr - clint_base;
    if (strb == '0) return;
    if (in_ram(addr)) begin
      ram_model[(addr - ram_base) >> 2] = merge_bytes(ram_model[(addr - ram_base) >> 2],
                                                      data, strb);
    end else if (in_clint(addr)) begin
      if (offset == msip_offset) msip_model = data[0];
      if (offset == mtimecmp_offset) mtimecmp_model[31:0] = data;
      if (offset == mtimecmp_offset + 4) mtimecmp_model[63:32] = data;
      if (offset == mtime_offset + 4) mtime_high_written = data;
      if (offset == mtime_offset) begin
        mtime_written = data;
        mtime_write_cycle = cycle;
      end
    end
  endtask

  `include "periph_checks.svh"

  periph_top #(
    .clock_rate(clock_rate),
    .ram_words(ram_words)
  ) periph_top_inst (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .mem_error(mem_error),
    .mtime(mtime),
    .msip(msip),
    .mtip(mtip)
  );

  always #(period / 2) clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
    time_loaded <= mem_valid && (mem_wstrb != '0) &&
                   ((mem_addr & 32'hffff_fff8) == clint_base + mtime_offset);
  end

  // every response is due exactly one cycle after its request
  always @(negedge clock) begin
    expect_t rsp;
    if (reset) begin
      if (pending.size() > 0 && pending[0].cycle + 1 == cycle) begin
        rsp = pending.pop_front();
        check_flag(mem_ready, 1'b1, "ready one cycle after valid");
        check_flag(mem_error, rsp.error, "error flag");
        if (rsp.ranged) begin
          check_time({32'd0, mem_rdata}, rsp.lo, rsp.hi, "mtime low word");
        end else begin
          check_data(mem_rdata, rsp.data, "read data");
        end
      end else begin
        check_flag(mem_ready, 1'b0, "ready without a request");
        check_flag(mem_error, 1'b0, "error without a request");
      end
    end
  end

  always @(negedge clock) begin
    if (reset && !time_loaded) begin
      check_time(mtime, prev_mtime, prev_mtime + 64'd1, "mtime step");
    end
    prev_mtime = mtime;
  end

  initial begin
    #((planned_requests + reset_cycles + margin_cycles) * period);
    abort_run("timeout: the requests did not finish in the expected time");
  end

  initial begin
    int idx;
    int kind;
    addr_t addr;
    data_t value;
    clock = 1'b0;
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    seed = 32'h1cd1;
    cycle = 0;
    msip_model = 1'b0;
    mtimecmp_model = '0;
    mtime_written = '0;
    mtime_high_written = '0;
    mtime_write_cycle = 0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b1;

    for (idx = 0; idx < ram_words; idx++) begin
      issue(ram_base + addr_t'(idx * 4), $random(seed), 4'hf);  // defined contents
    end
    for (idx = 0; idx < ram_pairs; idx++) begin
      addr = random_ram_addr();
      issue(addr, $random(seed), strb_t'($random(seed)));
      read_at(addr);
    end
    for (idx = 0; idx < ram_words; idx++) read_at(ram_base + addr_t'(idx * 4));

    issue(clint_base + msip_offset, 32'd1, 4'hf);
    read_at(clint_base + msip_offset);
    check_flag(msip, 1'b1, "msip port after set");
    issue(clint_base + msip_offset, 32'd0, 4'h1);
    read_at(clint_base + msip_offset);
    check_flag(msip, 1'b0, "msip port after clear");

    issue(clint_base + mtimecmp_offset, $random(seed), 4'hf);
    issue(clint_base + mtimecmp_offset + 4, 32'h8000_0000 | $random(seed), 4'hf);
    read_at(clint_base + mtimecmp_offset);
    read_at(clint_base + mtimecmp_offset + 4);
    idle_cycles(2);
    check_flag(mtip, 1'b0, "mtip with mtimecmp far ahead");
    issue(clint_base + mtimecmp_offset, 32'd0, 4'hf);
    issue(clint_base + mtimecmp_offset + 4, 32'd0, 4'hf);
    idle_cycles(1);
    check_flag(mtip, 1'b0, "mtip one cycle after clearing mtimecmp");
    idle_cycles(1);
    check_flag(mtip, 1'b1, "mtip two cycles after clearing mtimecmp");

    for (idx = 0; idx < 4; idx++) begin
      value = $random(seed) & 32'h0fff_ffff;
      issue(clint_base + mtime_offset + 4, $random(seed), 4'hf);
      issue(clint_base + mtime_offset, value, 4'hf);
      idle_cycles(int'($unsigned($random(seed)) % 16));
      read_mtime_low();
      read_at(clint_base + mtime_offset + 4);
    end

    issue(32'h4000_0000, $random(seed), 4'hf);  // between the windows
    read_at(32'h1000_0000);
    issue(ram_base + addr_t'(ram_words * 4), $random(seed), 4'hf);  // just past the RAM
    issue(clint_base + clint_span, $random(seed), 4'hf);
    read_at(clint_base - 4);
    for (idx = 0; idx < ram_words; idx++) read_at(ram_base + addr_t'(idx * 4));
    read_at(clint_base + msip_offset);

    for (idx = 0; idx < burst_len; idx++) begin
      kind = int'($unsigned($random(seed)) % 6);
      case (kind)
        0: issue(random_ram_addr(), $random(seed), strb_t'($random(seed)));
        1: read_at(random_ram_addr());
        2: read_at(32'h6000_0000 + addr_t'($unsigned($random(seed)) % 256));
        3: issue(clint_base + msip_offset, $random(seed), 4'hf);
        4: read_at(clint_base + msip_offset);
        default: issue(clint_base + mtimecmp_offset, $random(seed), strb_t'(kind));
      endcase
    end

    idle_cycles(3);
    if (pending.size() != 0) begin
      abort_run("some requests never got a response");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* compile.f */
+incdir+tests
logic/periph_pkg.sv
logic/mem_bus_if.sv
logic/bus_decoder.sv
logic/clint.sv
logic/scratch_ram.sv
logic/response_merge.sv
logic/periph_top.sv
tests/periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= periph_tb
RTL_TOP ?= periph_top
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
